// File: bench/tb_clock_gen.sv
// ##########################################################
// testbench clock (40 ns) and reset, high for 16 cycles
// ##########################################################
module tb_clock_gen (
  output logic rst_o,  // clock
  output logic clk_o   // reset, active high
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 16;

  initial begin
    rst_o = 1'b0;
    forever #HALF_PERIOD rst_o = ~rst_o;
  end

  initial begin
    clk_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge rst_o);
    @(negedge rst_o);  // release away from the sampling edge
    clk_o = 1'b0;
  end

endmodule

// File: bench/tb_spi_ctrl.sv
// ##########################################################
// testbench for the gopigo3 command forwarder: spi engine
// busy model, frame capture, directed tests and checks
// ##########################################################
module tb_spi_ctrl;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BUSY_CYCLES    = 16;     // engine shift time per byte
  localparam int TIMEOUT_CYCLES = 20000;  // 11 frames of up to ~1200 cycles plus 2000 idle and margin
  localparam int GUARD          = 500;    // slave select guard before the first byte
  localparam int ENA_PERIOD     = 12;

  logic        rst;                  // clock
  logic        clk;                  // reset
  logic        spi_ss_n;
  logic        spi_send;
  logic        ena_2clk;
  logic [7:0]  data_spi;
  logic        busy_spi;
  logic [23:0] cmd_val [7];          // value per slot in scan order
  logic        send_seen  = 1'b0;
  logic        ss_prev    = 1'b1;
  int          busy_left  = 0;
  int          seed       = 32'h3dc2_4bc5;
  int          errors     = 0;
  int          cycles     = 0;
  int          cur_len    = 0;       // bytes of the open frame
  int          ss_low_cnt = 0;
  int          ena_gap    = 0;
  int          frames_checked = 0;
  int          last_sent_slot = 0;   // predicts where the scan resumes
  logic [7:0]  cap_bytes [$];        // captured bytes of all frames in order
  int          cap_lens [$];
  logic [7:0]  exp_bytes [$];
  int          exp_lens [$];

  tb_clock_gen u_clock_gen (.rst_o(rst), .clk_o(clk));

  spi_ctrl_top u_spi_ctrl_top (
    .rst                (rst),
    .clk                (clk),
    .busy_spi_i         (busy_spi),
    .motor_pwm_left_i   (cmd_val[0][7:0]),
    .motor_pwm_rght_i   (cmd_val[1][7:0]),
    .motor_dps_limit_i  (cmd_val[2][15:0]),
    .motor_dps_left_i   (cmd_val[3][15:0]),
    .motor_dps_rght_i   (cmd_val[4][15:0]),
    .led_eye_left_rgb_i (cmd_val[5]),
    .led_eye_rght_rgb_i (cmd_val[6]),
    .spi_ss_n_o         (spi_ss_n),
    .spi_send_o         (spi_send),
    .ena_2clk_o         (ena_2clk),
    .data_spi_o         (data_spi)
  );

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // engine model raises busy one cycle after each send pulse
  always @(negedge rst) begin
    if (send_seen) begin
      busy_left = BUSY_CYCLES;
    end else if (busy_left > 0) begin
      busy_left = busy_left - 1;
    end
    send_seen = spi_send;
  end
  assign busy_spi = (busy_left > 0);

  // frame capture plus slave select and ena_2clk monitor
  always @(negedge rst) begin
    if (!clk) begin
      if (spi_send) begin
        check_eq("spi_ss_n_o at send", spi_ss_n, 1'b0);
        if (cur_len == 0) begin
          check_eq("opening guard cycles", ss_low_cnt, GUARD);
        end
        cap_bytes.push_back(data_spi);
        cur_len++;
      end
      if (!spi_ss_n) begin
        ss_low_cnt++;
        ena_gap++;
        check_eq("ena_2clk_o", ena_2clk, ena_gap == ENA_PERIOD);
        if (ena_gap == ENA_PERIOD) ena_gap = 0;
      end else begin
        check_eq("ena_2clk_o while deselected", ena_2clk, 1'b0);
        if (!ss_prev) begin  // slave select rose so the frame is done
          cap_lens.push_back(cur_len);
          cur_len = 0;
        end
        ss_low_cnt = 0;
        ena_gap    = 0;
      end
      ss_prev = spi_ss_n;
    end
  end

  always @(posedge rst) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles, expected frames never closed", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [23:0] slot_mask(input int slot);
    case (slot)
      0, 1:    return 24'h0000ff;  // pwm
      2, 3, 4: return 24'h00ffff;  // dps
      default: return 24'hffffff;  // rgb
    endcase
  endfunction

  // cyclic distance from the slot after the last one sent
  function automatic int scan_distance(input int slot);
    return (slot - last_sent_slot + 6) % 7;
  endfunction

  // random value that differs from the held one so a frame must follow
  task automatic drive_new_value(input int slot, output logic [23:0] v);
    v = cmd_val[slot];
    while (v == cmd_val[slot]) begin
      v = 24'($random(seed)) & slot_mask(slot);
    end
    cmd_val[slot] = v;
  endtask

  task automatic push_expected(input int slot, input logic [23:0] v);
    exp_bytes.push_back(8'h08);  // spi address
    case (slot)
      0, 1: begin
        exp_bytes.push_back(8'h0a);
        exp_bytes.push_back(slot == 0 ? 8'h01 : 8'h02);
        exp_bytes.push_back(v[7:0]);
        exp_lens.push_back(4);
      end
      2: begin
        exp_bytes.push_back(8'h0f);
        exp_bytes.push_back(8'h03);   // both motors
        exp_bytes.push_back(8'h00);   // power percent
        exp_bytes.push_back(v[15:8]);
        exp_bytes.push_back(v[7:0]);
        exp_lens.push_back(6);
      end
      3, 4: begin
        exp_bytes.push_back(8'h0e);
        exp_bytes.push_back(slot == 3 ? 8'h01 : 8'h02);
        exp_bytes.push_back(v[15:8]);
        exp_bytes.push_back(v[7:0]);
        exp_lens.push_back(5);
      end
      default: begin
        exp_bytes.push_back(8'h06);
        exp_bytes.push_back(slot == 5 ? 8'h02 : 8'h01);  // left eye is port 2
        exp_bytes.push_back(v[23:16]);
        exp_bytes.push_back(v[15:8]);
        exp_bytes.push_back(v[7:0]);
        exp_lens.push_back(6);
      end
    endcase
    last_sent_slot = slot;
  endtask

  // waits for every expected frame and compares byte by byte
  task automatic check_frames();
    int n;
    int len;
    int clen;
    int i;
    logic [7:0] want;
    n = exp_lens.size();
    while (cap_lens.size() < n) begin
      @(negedge rst);
    end
    repeat (n) begin
      len  = exp_lens.pop_front();
      clen = cap_lens.pop_front();
      check_eq($sformatf("frame %0d length", frames_checked), clen, len);
      for (i = 0; i < len; i++) begin
        want = exp_bytes.pop_front();
        if (i < clen) begin
          check_eq($sformatf("frame %0d byte %0d", frames_checked, i), cap_bytes[i], want);
        end
      end
      for (i = 0; i < clen; i++) begin
        want = cap_bytes.pop_front();
      end
      frames_checked++;
    end
  endtask

  task automatic check_quiet(input int n);
    int active;
    active = 0;
    repeat (n) begin
      @(negedge rst);
      if (!spi_ss_n || spi_send) active++;
    end
    check_eq("cycles with frame activity while idle", active, 0);
  endtask

  task automatic send_one(input int slot);
    logic [23:0] v;
    @(negedge rst);
    drive_new_value(slot, v);
    push_expected(slot, v);
    check_frames();
  endtask

  task automatic test_pwm();
    send_one(0);
    send_one(1);
    check_quiet(1000);  // inputs hold so nothing is resent
  endtask

  task automatic test_dps();
    send_one(2);
    send_one(4);
    send_one(3);
  endtask

  task automatic test_eye();
    send_one(5);
    send_one(6);
  endtask

  // two slots change while a frame runs and the scan is parked on the slot in flight
  task automatic test_two_changes();
    logic [23:0] va;
    logic [23:0] vb;
    logic [23:0] vc;
    @(negedge rst);
    drive_new_value(5, va);
    push_expected(5, va);
    while (spi_ss_n) begin
      @(negedge rst);
    end
    drive_new_value(1, vb);
    drive_new_value(6, vc);
    if (scan_distance(1) < scan_distance(6)) begin
      push_expected(1, vb);
      push_expected(6, vc);
    end else begin
      push_expected(6, vc);
      push_expected(1, vb);
    end
    check_frames();
  endtask

  // the monitor checks ena_2clk_o on every cycle of the frame and after it
  task automatic test_clock_enable();
    send_one(3);
    check_quiet(3 * ENA_PERIOD);  // several divider periods with slave select high
  endtask

  initial begin
    cmd_val = '{default: '0};
    @(negedge clk);  // reset released
    repeat (2) @(negedge rst);
    check_quiet(1000);  // all inputs equal the cleared shadows
    test_pwm();
    test_dps();
    test_eye();
    test_two_changes();
    test_clock_enable();
    $display("errors: %0d, frames checked: %0d, cycles: %0d", errors, frames_checked, cycles);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the command forwarder testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_spi_ctrl_sim

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_spi_ctrl \
  -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see $LOG"
exit 1

// File: sources.f
verilog/gopigo_pkg.sv
verilog/spi_cmd_if.sv
verilog/cmd_scanner.sv
verilog/frame_builder.sv
verilog/spi_sequencer.sv
verilog/spi_ctrl_top.sv
bench/tb_clock_gen.sv
bench/tb_spi_ctrl.sv

// File: verilog/cmd_scanner.sv
// ##########################################################
// shadow registers of the last sent commands, one shared
// comparator and the round-robin slot counter
// ##########################################################
module cmd_scanner (
  input  logic                         rst,  // clock
  input  logic                         clk,  // async reset, active high
  input  logic [gopigo_pkg::PWM_W-1:0] motor_pwm_left_i,
  input  logic [gopigo_pkg::PWM_W-1:0] motor_pwm_rght_i,
  input  logic [gopigo_pkg::DPS_W-1:0] motor_dps_limit_i,
  input  logic [gopigo_pkg::DPS_W-1:0] motor_dps_left_i,
  input  logic [gopigo_pkg::DPS_W-1:0] motor_dps_rght_i,
  input  logic [gopigo_pkg::RGB_W-1:0] led_eye_left_rgb_i,
  input  logic [gopigo_pkg::RGB_W-1:0] led_eye_rght_rgb_i,
  spi_cmd_if.scanner                   cmd
);

  // last value sent per slot
  logic [gopigo_pkg::PWM_W-1:0] pwm_left_q;
  logic [gopigo_pkg::PWM_W-1:0] pwm_rght_q;
  logic [gopigo_pkg::DPS_W-1:0] dps_limit_q;
  logic [gopigo_pkg::DPS_W-1:0] dps_left_q;
  logic [gopigo_pkg::DPS_W-1:0] dps_rght_q;
  logic [gopigo_pkg::RGB_W-1:0] eye_left_q;
  logic [gopigo_pkg::RGB_W-1:0] eye_rght_q;

  logic [gopigo_pkg::CMP_W-1:0] cmp_new;  // current input, zero extended
  logic [gopigo_pkg::CMP_W-1:0] cmp_old;  // matching shadow, zero extended
  gopigo_pkg::cmd_slot_e        slot_q;

  // route one slot onto the single comparator
  always_comb begin
    cmp_new = '0;
    cmp_old = '0;
    case (slot_q)
      gopigo_pkg::PWM_LEFT: begin
        cmp_new[gopigo_pkg::PWM_W-1:0] = motor_pwm_left_i;
        cmp_old[gopigo_pkg::PWM_W-1:0] = pwm_left_q;
      end
      gopigo_pkg::PWM_RGHT: begin
        cmp_new[gopigo_pkg::PWM_W-1:0] = motor_pwm_rght_i;
        cmp_old[gopigo_pkg::PWM_W-1:0] = pwm_rght_q;
      end
      gopigo_pkg::DPS_LIMIT: begin
        cmp_new[gopigo_pkg::DPS_W-1:0] = motor_dps_limit_i;
        cmp_old[gopigo_pkg::DPS_W-1:0] = dps_limit_q;
      end
      gopigo_pkg::DPS_LEFT: begin
        cmp_new[gopigo_pkg::DPS_W-1:0] = motor_dps_left_i;
        cmp_old[gopigo_pkg::DPS_W-1:0] = dps_left_q;
      end
      gopigo_pkg::DPS_RGHT: begin
        cmp_new[gopigo_pkg::DPS_W-1:0] = motor_dps_rght_i;
        cmp_old[gopigo_pkg::DPS_W-1:0] = dps_rght_q;
      end
      gopigo_pkg::EYE_LEFT: begin
        cmp_new[gopigo_pkg::RGB_W-1:0] = led_eye_left_rgb_i;
        cmp_old[gopigo_pkg::RGB_W-1:0] = eye_left_q;
      end
      gopigo_pkg::EYE_RGHT: begin
        cmp_new[gopigo_pkg::RGB_W-1:0] = led_eye_rght_rgb_i;
        cmp_old[gopigo_pkg::RGB_W-1:0] = eye_rght_q;
      end
      default: ;  // unused code compares equal
    endcase
  end

  assign cmd.change = (cmp_new != cmp_old);
  assign cmd.slot   = slot_q;

  // shadow takes the input in the same cycle the frame is built
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      pwm_left_q  <= '0;
      pwm_rght_q  <= '0;
      dps_limit_q <= '0;
      dps_left_q  <= '0;
      dps_rght_q  <= '0;
      eye_left_q  <= '0;
      eye_rght_q  <= '0;
    end else if (cmd.load) begin
      case (slot_q)
        gopigo_pkg::PWM_LEFT:  pwm_left_q  <= motor_pwm_left_i;
        gopigo_pkg::PWM_RGHT:  pwm_rght_q  <= motor_pwm_rght_i;
        gopigo_pkg::DPS_LIMIT: dps_limit_q <= motor_dps_limit_i;
        gopigo_pkg::DPS_LEFT:  dps_left_q  <= motor_dps_left_i;
        gopigo_pkg::DPS_RGHT:  dps_rght_q  <= motor_dps_rght_i;
        gopigo_pkg::EYE_LEFT:  eye_left_q  <= led_eye_left_rgb_i;
        gopigo_pkg::EYE_RGHT:  eye_rght_q  <= led_eye_rght_rgb_i;
        default: ;
      endcase
    end
  end

  // round robin, parks on a changed slot until it is sent
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      slot_q <= gopigo_pkg::PWM_LEFT;
    end else if (cmd.scan_en && !cmd.change) begin
      if (slot_q == gopigo_pkg::LAST_SLOT) begin
        slot_q <= gopigo_pkg::PWM_LEFT;  // wrap
      end else begin
        slot_q <= gopigo_pkg::cmd_slot_e'(slot_q + 1'b1);
      end
    end
  end

endmodule

// File: verilog/frame_builder.sv
// ##########################################################
// spi frame registers, filled for the current slot on load,
// and the byte picked by the sequencer's index
// ##########################################################
module frame_builder (
  input  logic                         rst,  // clock
  input  logic                         clk,  // async reset, active high
  input  logic [gopigo_pkg::PWM_W-1:0] motor_pwm_left_i,
  input  logic [gopigo_pkg::PWM_W-1:0] motor_pwm_rght_i,
  input  logic [gopigo_pkg::DPS_W-1:0] motor_dps_limit_i,
  input  logic [gopigo_pkg::DPS_W-1:0] motor_dps_left_i,
  input  logic [gopigo_pkg::DPS_W-1:0] motor_dps_rght_i,
  input  logic [gopigo_pkg::RGB_W-1:0] led_eye_left_rgb_i,
  input  logic [gopigo_pkg::RGB_W-1:0] led_eye_rght_rgb_i,
  spi_cmd_if.builder                   cmd
);

  logic [gopigo_pkg::BYTE_W-1:0] frame_q [gopigo_pkg::MAX_FRAME];
  logic [gopigo_pkg::BYTE_W-1:0] frame_d [gopigo_pkg::MAX_FRAME];
  logic [gopigo_pkg::BIDX_W-1:0] last_idx_q;
  logic [gopigo_pkg::BIDX_W-1:0] last_idx_d;

  // next frame for the slot under compare
  always_comb begin
    foreach (frame_d[i]) begin
      frame_d[i] = frame_q[i];  // bytes past last_idx are never sent
    end
    frame_d[0] = gopigo_pkg::SPI_ADDR;
    last_idx_d = last_idx_q;
    case (cmd.slot)
      gopigo_pkg::PWM_LEFT, gopigo_pkg::PWM_RGHT: begin
        frame_d[1] = gopigo_pkg::SET_MOTOR_PWM;
        frame_d[2] = (cmd.slot == gopigo_pkg::PWM_LEFT) ? gopigo_pkg::MOTOR_LEFT
                                                         : gopigo_pkg::MOTOR_RIGHT;
        frame_d[3] = (cmd.slot == gopigo_pkg::PWM_LEFT) ? motor_pwm_left_i
                                                         : motor_pwm_rght_i;
        last_idx_d = 3'd3;
      end
      gopigo_pkg::DPS_LIMIT: begin
        frame_d[1] = gopigo_pkg::SET_MOTOR_LIMITS;
        frame_d[2] = gopigo_pkg::MOTOR_BOTH;
        frame_d[3] = '0;                        // power limit 0, dps limit only
        frame_d[4] = motor_dps_limit_i[15:8];   // msb first
        frame_d[5] = motor_dps_limit_i[7:0];
        last_idx_d = 3'd5;
      end
      gopigo_pkg::DPS_LEFT, gopigo_pkg::DPS_RGHT: begin
        frame_d[1] = gopigo_pkg::SET_MOTOR_DPS;
        if (cmd.slot == gopigo_pkg::DPS_LEFT) begin
          frame_d[2] = gopigo_pkg::MOTOR_LEFT;
          {frame_d[3], frame_d[4]} = motor_dps_left_i;
        end else begin
          frame_d[2] = gopigo_pkg::MOTOR_RIGHT;
          {frame_d[3], frame_d[4]} = motor_dps_rght_i;
        end
        last_idx_d = 3'd4;
      end
      gopigo_pkg::EYE_LEFT: begin
        frame_d[1] = gopigo_pkg::SET_LED;
        frame_d[2] = gopigo_pkg::LED_EYE_LEFT;
        {frame_d[3], frame_d[4], frame_d[5]} = led_eye_left_rgb_i;  // r, g, b
        last_idx_d = 3'd5;
      end
      gopigo_pkg::EYE_RGHT: begin
        frame_d[1] = gopigo_pkg::SET_LED;
        frame_d[2] = gopigo_pkg::LED_EYE_RIGHT;
        {frame_d[3], frame_d[4], frame_d[5]} = led_eye_rght_rgb_i;
        last_idx_d = 3'd5;
      end
      default: ;
    endcase
  end

  // frame payload, loaded together with the scanner's shadow
  always_ff @(posedge rst) begin
    if (cmd.load) begin
      frame_q <= frame_d;
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      last_idx_q <= '0;
    end else if (cmd.load) begin
      last_idx_q <= last_idx_d;
    end
  end

  assign cmd.byte_data = frame_q[cmd.byte_idx];  // follows the index, no latency
  assign cmd.last_idx  = last_idx_q;

endmodule

// File: verilog/gopigo_pkg.sv
// ##########################################################
// gopigo3 spi forwarder definitions: command slots, message
// types, port ids, sequencer states, widths and timing
// ##########################################################
package gopigo_pkg;

  // data widths
  localparam int PWM_W  = 8;   // signed pwm, -100 to 100
  localparam int DPS_W  = 16;  // degrees per second
  localparam int RGB_W  = 24;  // R[23:16] G[15:8] B[7:0]
  localparam int CMP_W  = 32;  // shared comparator, widest command fits
  localparam int BYTE_W = 8;

  localparam int MAX_FRAME = 6;  // addr, type, port and up to 3 payload bytes
  localparam int BIDX_W    = 3;  // byte index into a frame

  // command slots in scan order
  localparam int NUM_SLOTS = 7;
  localparam int SLOT_W    = $clog2(NUM_SLOTS);

  typedef enum logic [SLOT_W-1:0] {
    PWM_LEFT  = 3'd0,
    PWM_RGHT  = 3'd1,
    DPS_LIMIT = 3'd2,  // shared by both motors
    DPS_LEFT  = 3'd3,
    DPS_RGHT  = 3'd4,
    EYE_LEFT  = 3'd5,
    EYE_RGHT  = 3'd6
  } cmd_slot_e;

  localparam cmd_slot_e LAST_SLOT = EYE_RGHT;  // scan wraps here

  // gopigo3 spi message types
  typedef enum logic [BYTE_W-1:0] {
    SET_LED          = 8'h06,
    SET_MOTOR_PWM    = 8'h0A,
    SET_MOTOR_DPS    = 8'h0E,
    SET_MOTOR_LIMITS = 8'h0F
  } msg_type_e;

  localparam logic [BYTE_W-1:0] SPI_ADDR = 8'h08;  // first byte of every frame

  // port identifiers
  localparam logic [BYTE_W-1:0] MOTOR_LEFT    = 8'h01;
  localparam logic [BYTE_W-1:0] MOTOR_RIGHT   = 8'h02;
  localparam logic [BYTE_W-1:0] MOTOR_BOTH    = 8'h03;
  localparam logic [BYTE_W-1:0] LED_EYE_RIGHT = 8'h01;
  localparam logic [BYTE_W-1:0] LED_EYE_LEFT  = 8'h02;

  // transmit sequencer states
  typedef enum logic [2:0] {
    CHK_NEW, LOAD, GUARD_ON, SEND, SEND_WAIT, BUSY_WAIT, GUARD_OFF, FINISH
  } seq_state_e;

  // timing
  localparam int GUARD_CYCLES = 500;  // slave select guard, simulation length
  localparam int GUARD_W      = $clog2(GUARD_CYCLES);
  localparam int SCK_DIV      = 12;   // ena_2clk period in clock cycles
  localparam int SCK_W        = $clog2(SCK_DIV);

endpackage

// File: verilog/spi_cmd_if.sv
// ##########################################################
// handshake between change scanner, frame builder and
// transmit sequencer
// ##########################################################
interface spi_cmd_if;

  logic                            scan_en;    // sequencer idle, scan running
  logic                            load;       // one cycle, latch slot and frame
  logic [gopigo_pkg::BIDX_W-1:0]   byte_idx;   // byte being sent
  gopigo_pkg::cmd_slot_e           slot;       // slot under compare
  logic                            change;     // input differs from shadow
  logic [gopigo_pkg::BYTE_W-1:0]   byte_data;  // frame byte at byte_idx
  logic [gopigo_pkg::BIDX_W-1:0]   last_idx;   // last byte of the frame

  modport scanner (
    input  scan_en, load,
    output slot, change
  );

  modport builder (
    input  load, slot, byte_idx,
    output byte_data, last_idx
  );

  modport sequencer (
    input  change, last_idx,
    output scan_en, load, byte_idx
  );

endinterface

// File: verilog/spi_ctrl_top.sv
// ##########################################################
// gopigo3 command forwarder top: scanner, frame builder
// and spi sequencer joined by the command interface
// ##########################################################
module spi_ctrl_top (
  input  logic                          rst,         // clock
  input  logic                          clk,         // async reset, active high
  input  logic                          busy_spi_i,  // from spi byte engine
  input  logic [gopigo_pkg::PWM_W-1:0]  motor_pwm_left_i,
  input  logic [gopigo_pkg::PWM_W-1:0]  motor_pwm_rght_i,
  input  logic [gopigo_pkg::DPS_W-1:0]  motor_dps_limit_i,
  input  logic [gopigo_pkg::DPS_W-1:0]  motor_dps_left_i,
  input  logic [gopigo_pkg::DPS_W-1:0]  motor_dps_rght_i,
  input  logic [gopigo_pkg::RGB_W-1:0]  led_eye_left_rgb_i,
  input  logic [gopigo_pkg::RGB_W-1:0]  led_eye_rght_rgb_i,
  output logic                          spi_ss_n_o,
  output logic                          spi_send_o,
  output logic                          ena_2clk_o,
  output logic [gopigo_pkg::BYTE_W-1:0] data_spi_o   // valid with spi_send_o
);

  spi_cmd_if u_cmd_if ();

  cmd_scanner u_cmd_scanner (
    .rst                (rst),
    .clk                (clk),
    .motor_pwm_left_i   (motor_pwm_left_i),
    .motor_pwm_rght_i   (motor_pwm_rght_i),
    .motor_dps_limit_i  (motor_dps_limit_i),
    .motor_dps_left_i   (motor_dps_left_i),
    .motor_dps_rght_i   (motor_dps_rght_i),
    .led_eye_left_rgb_i (led_eye_left_rgb_i),
    .led_eye_rght_rgb_i (led_eye_rght_rgb_i),
    .cmd                (u_cmd_if.scanner)
  );

  frame_builder u_frame_builder (
    .rst                (rst),
    .clk                (clk),
    .motor_pwm_left_i   (motor_pwm_left_i),
    .motor_pwm_rght_i   (motor_pwm_rght_i),
    .motor_dps_limit_i  (motor_dps_limit_i),
    .motor_dps_left_i   (motor_dps_left_i),
    .motor_dps_rght_i   (motor_dps_rght_i),
    .led_eye_left_rgb_i (led_eye_left_rgb_i),
    .led_eye_rght_rgb_i (led_eye_rght_rgb_i),
    .cmd                (u_cmd_if.builder)
  );

  spi_sequencer u_spi_sequencer (
    .rst        (rst),
    .clk        (clk),
    .busy_spi_i (busy_spi_i),
    .cmd        (u_cmd_if.sequencer),
    .spi_ss_n_o (spi_ss_n_o),
    .spi_send_o (spi_send_o),
    .ena_2clk_o (ena_2clk_o)
  );

  assign data_spi_o = u_cmd_if.byte_data;  // byte under the sequencer's index

endmodule

// File: verilog/spi_sequencer.sv
// ##########################################################
// transmit fsm with byte counter and slave select guard
// timer, plus the ena_2clk divider for the spi engine
// ##########################################################
module spi_sequencer (
  input  logic       rst,         // clock
  input  logic       clk,         // async reset, active high
  input  logic       busy_spi_i,  // spi engine shifting
  spi_cmd_if.sequencer cmd,
  output logic       spi_ss_n_o,  // slave select, active low
  output logic       spi_send_o,  // one cycle, start a byte
  output logic       ena_2clk_o   // spi clock enable, twice sck
);

  gopigo_pkg::seq_state_e        state_q;
  gopigo_pkg::seq_state_e        state_d;
  logic [gopigo_pkg::BIDX_W-1:0] byte_cnt_q;
  logic                          byte_inc;
  logic [gopigo_pkg::GUARD_W-1:0] guard_cnt_q;
  logic                          guard_run;
  logic                          guard_done;
  logic [gopigo_pkg::SCK_W-1:0]  sck_cnt_q;
  logic                          sck_end;
  logic                          ss_active;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state_q <= gopigo_pkg::CHK_NEW;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d  = state_q;
    byte_inc = 1'b0;
    case (state_q)
      gopigo_pkg::CHK_NEW: begin
        if (cmd.change) state_d = gopigo_pkg::LOAD;
      end
      gopigo_pkg::LOAD: state_d = gopigo_pkg::GUARD_ON;  // shadow and frame latch here
      gopigo_pkg::GUARD_ON: begin
        if (guard_done) state_d = gopigo_pkg::SEND;      // engine idle, byte 0 goes now
      end
      gopigo_pkg::SEND: state_d = gopigo_pkg::SEND_WAIT;
      gopigo_pkg::SEND_WAIT: begin
        if (busy_spi_i) state_d = gopigo_pkg::BUSY_WAIT; // engine took the byte
      end
      gopigo_pkg::BUSY_WAIT: begin
        // no timeout, busy is the only back-pressure
        if (!busy_spi_i) begin
          if (byte_cnt_q == cmd.last_idx) begin
            state_d = gopigo_pkg::GUARD_OFF;
          end else begin
            byte_inc = 1'b1;
            state_d  = gopigo_pkg::SEND;
          end
        end
      end
      gopigo_pkg::GUARD_OFF: begin
        if (guard_done) state_d = gopigo_pkg::FINISH;
      end
      gopigo_pkg::FINISH: state_d = gopigo_pkg::CHK_NEW;
    endcase
  end

  // byte index, restarts for every frame
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      byte_cnt_q <= '0;
    end else if (state_q == gopigo_pkg::CHK_NEW) begin
      byte_cnt_q <= '0;
    end else if (byte_inc) begin
      byte_cnt_q <= byte_cnt_q + 1'b1;
    end
  end

  // guard timer, shared by opening and closing guard
  assign guard_run  = (state_q == gopigo_pkg::GUARD_ON) || (state_q == gopigo_pkg::GUARD_OFF);
  assign guard_done = guard_run &&
                      (guard_cnt_q == gopigo_pkg::GUARD_W'(gopigo_pkg::GUARD_CYCLES - 1));

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      guard_cnt_q <= '0;
    end else if (guard_run && !guard_done) begin
      guard_cnt_q <= guard_cnt_q + 1'b1;
    end else begin
      guard_cnt_q <= '0;
    end
  end

  // slave select low from opening guard to end of closing guard
  assign ss_active = (state_q == gopigo_pkg::GUARD_ON)  || (state_q == gopigo_pkg::SEND) ||
                     (state_q == gopigo_pkg::SEND_WAIT) || (state_q == gopigo_pkg::BUSY_WAIT) ||
                     (state_q == gopigo_pkg::GUARD_OFF);

  // clock enable divider, idle at zero while deselected
  assign sck_end = ss_active && (sck_cnt_q == gopigo_pkg::SCK_W'(gopigo_pkg::SCK_DIV - 1));

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      sck_cnt_q <= '0;
    end else if (!ss_active || sck_end) begin
      sck_cnt_q <= '0;
    end else begin
      sck_cnt_q <= sck_cnt_q + 1'b1;
    end
  end

  assign spi_ss_n_o = !ss_active;
  assign spi_send_o = (state_q == gopigo_pkg::SEND);
  assign ena_2clk_o = sck_end;

  assign cmd.scan_en  = (state_q == gopigo_pkg::CHK_NEW);  // scan frozen during a frame
  assign cmd.load     = (state_q == gopigo_pkg::LOAD);
  assign cmd.byte_idx = byte_cnt_q;

endmodule
